// File: src.f
+incdir+source
source/lc3b_types.sv
source/mem_port_if.sv
source/stage_reg.sv
source/if_stage.sv
source/id_stage.sv
source/ex_stage.sv
source/mem_stage.sv
source/cpu_datapath.sv
source/mem_arbiter.sv
source/cpu.sv
verification/sim_memory.sv
verification/tb_cpu.sv

// File: verification/tb_cpu.sv
`include "lc3b_consts.svh"

module tb_cpu import lc3b_types::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // longest program runs about 60 instructions, each fetch and data access
    // takes at most 4 cycles plus a resp cycle, so this leaves ample margin
    localparam int max_cycles = 5000;

    logic clk;
    logic rst;
    logic fixed_latency;
    logic mem_read;
    logic mem_write;
    lc3b_word mem_address;
    lc3b_word mem_wdata;
    logic mem_resp;
    lc3b_word mem_rdata;
    logic bus_error;

    lc3b_word prog [$];
    lc3b_word exp_addr [$];
    lc3b_word exp_data [$];
    lc3b_word saved_addr [$];
    lc3b_word saved_data [$];

    cpu u_dut (
        .clk(clk),
        .rst(rst),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_resp(mem_resp),
        .mem_rdata(mem_rdata)
    );

    sim_memory u_mem (
        .clk(clk),
        .rst(rst),
        .fixed_latency(fixed_latency),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_resp(mem_resp),
        .mem_rdata(mem_rdata),
        .bus_error(bus_error)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(string what, lc3b_word expected, lc3b_word actual);
        assert (actual === expected) else begin
            $display("[ERROR] %s: expected %h, actual %h", what, expected, actual);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        assert (!bus_error) else abort_run();
    end

    function automatic lc3b_word rr_form(logic [3:0] op, int dr, int sr1, int sr2);
        return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
    endfunction

    function automatic lc3b_word ri_form(logic [3:0] op, int dr, int sr1, int imm);
        return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
    endfunction

    function automatic lc3b_word not_form(int dr, int sr);
        return {`OP_NOT, 3'(dr), 3'(sr), 6'h3f};
    endfunction

    // offsets count words, so -1 from R7 (always zero) is address 0xfffe
    function automatic lc3b_word mem_form(logic [3:0] op, int r, int base, int off);
        return {op, 3'(r), 3'(base), 6'(off)};
    endfunction

    function automatic lc3b_word br_form(int nzp, int off);
        return {`OP_BR, 3'(nzp), 9'(off)};
    endfunction

    // program words first, then a pattern taken from the whole word address
    function automatic lc3b_word initial_word(int idx);
        if (idx < prog.size()) begin
            return prog[idx];
        end
        return 16'((idx * 40503) ^ 16'h3c3c);
    endfunction

    task automatic add_done_tail();
        prog.push_back(mem_form(`OP_STR, 7, 7, -1));
        prog.push_back(br_form(3'b111, -1));
    endtask

    // architectural run of the program, one instruction at a time
    task automatic reference_run(string name);
        lc3b_word r [`LC3B_NUM_REGS];
        lc3b_word dmem [int];
        lc3b_word pc;
        lc3b_word ir;
        lc3b_word b;
        lc3b_word addr;
        lc3b_word res;
        logic [2:0] cc;
        logic done;
        int steps;
        exp_addr.delete();
        exp_data.delete();
        foreach (r[i]) r[i] = '0;
        pc = `LC3B_RESET_PC;
        cc = 3'b010;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            ir = dmem.exists(pc[15:1]) ? dmem[pc[15:1]] : initial_word(pc[15:1]);
            pc = pc + 16'd2;
            steps++;
            b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
            addr = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
            res = '0;
            case (ir[15:12])
                `OP_ADD: res = r[ir[8:6]] + b;
                `OP_AND: res = r[ir[8:6]] & b;
                `OP_NOT: res = ~r[ir[8:6]];
                `OP_LDR: res = dmem.exists(addr[15:1]) ? dmem[addr[15:1]]
                                                       : initial_word(addr[15:1]);
                `OP_STR: begin
                    dmem[addr[15:1]] = r[ir[11:9]];
                    exp_addr.push_back(addr);
                    exp_data.push_back(r[ir[11:9]]);
                    done = (addr == 16'hfffe);
                end
                `OP_BR: begin
                    if ((ir[11:9] & cc) != 3'b000) begin
                        pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
                    end
                end
                default: begin
                end
            endcase
            if (ir[15:12] inside {`OP_ADD, `OP_AND, `OP_NOT, `OP_LDR}) begin
                r[ir[11:9]] = res;
                cc = {res[15], res == 16'h0000, !res[15] && res != 16'h0000};
            end
        end
        assert (done) else begin
            $display("reference run of %s never reached the done store", name);
            abort_run();
        end
    endtask

    task automatic run_program(string name, logic fixed);
        int cycles;
        logic first_seen;
        logic done_seen;
        @(posedge clk);
        rst <= 1'b1;
        fixed_latency <= fixed;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i == 1) begin
                for (int w = 0; w < 32768; w++) begin
                    u_mem.mem[w] = initial_word(w);
                end
            end
            if (i >= 1) begin
                check_value({name, " bus idle in reset"}, 16'h0, {mem_read, mem_write});
            end
        end
        rst <= 1'b0;
        cycles = 0;
        first_seen = 1'b0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(posedge clk);
            cycles++;
            assert (cycles < max_cycles) else begin
                $display("timeout: %s did not reach the done store in %0d cycles",
                         name, max_cycles);
                abort_run();
            end
            if (cycles == 1) begin
                check_value({name, " bus idle after reset"}, 16'h0, {mem_read, mem_write});
            end
            if (!first_seen && (mem_read || mem_write)) begin
                first_seen = 1'b1;
                check_value({name, " first access is a read"}, 16'h1, mem_read);
                check_value({name, " first fetch address"}, `LC3B_RESET_PC, mem_address);
            end
            done_seen = mem_write && mem_resp && mem_address == 16'hfffe;
        end
    endtask

    task automatic check_store_log(string name);
        reference_run(name);
        check_value({name, " store count"}, 16'(exp_addr.size()), 16'(u_mem.log_addr.size()));
        foreach (exp_addr[i]) begin
            check_value($sformatf("%s store %0d address", name, i), exp_addr[i],
                        u_mem.log_addr[i]);
            check_value($sformatf("%s store %0d data", name, i), exp_data[i],
                        u_mem.log_data[i]);
        end
    endtask

    task automatic reset_and_first_fetch();
        prog.delete();
        prog.push_back(ri_form(`OP_ADD, 1, 7, 9));
        prog.push_back(mem_form(`OP_STR, 1, 7, -2));
        add_done_tail();
        run_program("reset", 1'b0);
        check_store_log("reset");
    endtask

    task automatic alu_forwarding();
        prog.delete();
        prog.push_back(ri_form(`OP_ADD, 1, 7, 7));
        prog.push_back(ri_form(`OP_ADD, 2, 1, -3));
        prog.push_back(rr_form(`OP_ADD, 3, 1, 2));
        prog.push_back(ri_form(`OP_AND, 4, 3, 6));
        prog.push_back(not_form(5, 4));
        prog.push_back(rr_form(`OP_AND, 6, 5, 3));
        prog.push_back(rr_form(`OP_ADD, 1, 6, 5));
        for (int r = 1; r <= 6; r++) begin
            prog.push_back(mem_form(`OP_STR, r, 7, -1 - r));
        end
        add_done_tail();
        run_program("alu forwarding", 1'b0);
        check_store_log("alu forwarding");
    endtask

    task automatic loads_and_stores();
        prog.delete();
        prog.push_back(ri_form(`OP_ADD, 1, 7, 12));
        prog.push_back(mem_form(`OP_STR, 1, 7, -8));
        prog.push_back(mem_form(`OP_LDR, 2, 7, -8));
        prog.push_back(ri_form(`OP_ADD, 3, 2, 1));
        prog.push_back(mem_form(`OP_LDR, 4, 7, -20));
        prog.push_back(rr_form(`OP_ADD, 4, 4, 4));
        prog.push_back(mem_form(`OP_STR, 4, 7, -9));
        prog.push_back(mem_form(`OP_STR, 3, 7, -10));
        prog.push_back(mem_form(`OP_LDR, 5, 7, -10));
        prog.push_back(mem_form(`OP_STR, 5, 7, -11));
        add_done_tail();
        run_program("loads and stores", 1'b0);
        check_store_log("loads and stores");
    endtask

    task automatic branch_conditions();
        prog.delete();
        prog.push_back(ri_form(`OP_ADD, 1, 7, -1));
        prog.push_back(br_form(3'b100, 1));
        prog.push_back(mem_form(`OP_STR, 1, 7, -12));
        prog.push_back(br_form(3'b010, 1));
        prog.push_back(ri_form(`OP_ADD, 2, 7, 3));
        prog.push_back(br_form(3'b001, 1));
        prog.push_back(ri_form(`OP_ADD, 2, 2, 5));
        prog.push_back(br_form(3'b110, 1));
        prog.push_back(mem_form(`OP_STR, 2, 7, -13));
        prog.push_back(ri_form(`OP_AND, 3, 7, 0));
        prog.push_back(br_form(3'b010, 2));
        prog.push_back(mem_form(`OP_STR, 3, 7, -14));
        prog.push_back(mem_form(`OP_STR, 1, 7, -15));
        prog.push_back(br_form(3'b101, 1));
        prog.push_back(ri_form(`OP_ADD, 3, 3, 2));
        prog.push_back(br_form(3'b111, 1));
        prog.push_back(mem_form(`OP_STR, 3, 7, -16));
        prog.push_back(mem_form(`OP_STR, 3, 7, -17));
        // counted loop with a backward branch
        prog.push_back(ri_form(`OP_ADD, 4, 7, 3));
        prog.push_back(ri_form(`OP_ADD, 5, 5, 2));
        prog.push_back(ri_form(`OP_ADD, 4, 4, -1));
        prog.push_back(br_form(3'b001, -3));
        prog.push_back(mem_form(`OP_STR, 5, 7, -18));
        add_done_tail();
        run_program("branches", 1'b0);
        check_store_log("branches");
    endtask

    task automatic arbitration_latency();
        prog.delete();
        prog.push_back(ri_form(`OP_ADD, 1, 7, 5));
        prog.push_back(mem_form(`OP_STR, 1, 7, -2));
        prog.push_back(mem_form(`OP_STR, 1, 7, -3));
        prog.push_back(mem_form(`OP_LDR, 2, 7, -2));
        prog.push_back(mem_form(`OP_LDR, 3, 7, -3));
        prog.push_back(rr_form(`OP_ADD, 4, 2, 3));
        prog.push_back(mem_form(`OP_STR, 4, 7, -4));
        prog.push_back(mem_form(`OP_LDR, 5, 7, -4));
        prog.push_back(not_form(6, 5));
        prog.push_back(mem_form(`OP_STR, 6, 7, -5));
        add_done_tail();
        run_program("arbitration fixed", 1'b1);
        check_store_log("arbitration fixed");
        saved_addr = u_mem.log_addr;
        saved_data = u_mem.log_data;
        // the random latency run must reproduce the fixed latency log
        run_program("arbitration random", 1'b0);
        check_value("arbitration log length", 16'(saved_addr.size()),
                    16'(u_mem.log_addr.size()));
        foreach (saved_addr[i]) begin
            check_value($sformatf("arbitration store %0d address", i), saved_addr[i],
                        u_mem.log_addr[i]);
            check_value($sformatf("arbitration store %0d data", i), saved_data[i],
                        u_mem.log_data[i]);
        end
    endtask

    initial begin
        rst = 1'b1;
        fixed_latency = 1'b0;
        reset_and_first_fetch();
        alu_forwarding();
        loads_and_stores();
        branch_conditions();
        arbitration_latency();
        if (bus_error) begin
            abort_run();
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule : tb_cpu

// File: verification/sim_memory.sv
module sim_memory import lc3b_types::*; (
    input logic clk,
    input logic rst,
    input logic fixed_latency,
    input logic mem_read,
    input logic mem_write,
    input lc3b_word mem_address,
    input lc3b_word mem_wdata,
    output logic mem_resp,
    output lc3b_word mem_rdata,
    output logic bus_error
);

    timeunit 1ns;
    timeprecision 1ps;

    lc3b_word mem [32768];
    lc3b_word log_addr [$];
    lc3b_word log_data [$];

    int unsigned delay;
    int unsigned count;
    logic pending;
    logic [1:0] req_kind;
    lc3b_word req_addr;

    // one process owns the random stream, so the seed fixes every latency
    initial begin
        mem_resp = 1'b0;
        mem_rdata = '0;
        bus_error = 1'b0;
        pending = 1'b0;
        count = 0;
        delay = 1;
        void'($urandom(55));
        forever begin
            @(posedge clk);
            if (rst) begin
                mem_resp <= 1'b0;
                pending = 1'b0;
                log_addr.delete();
                log_data.delete();
            end else begin
                if (mem_read && mem_write) begin
                    $display("bus error: read and write are high together at %h", mem_address);
                    bus_error <= 1'b1;
                end
                if (pending && (req_kind != {mem_read, mem_write} || req_addr != mem_address)) begin
                    $display("bus error: the request at %h changed before its resp", req_addr);
                    bus_error <= 1'b1;
                end
                if (mem_resp) begin
                    // resp is a single cycle pulse
                    mem_resp <= 1'b0;
                end else if (mem_read || mem_write) begin
                    if (!pending) begin
                        pending = 1'b1;
                        count = 0;
                        req_kind = {mem_read, mem_write};
                        req_addr = mem_address;
                        delay = fixed_latency ? 1 : $urandom_range(4, 1);
                    end
                    count++;
                    if (count >= delay) begin
                        pending = 1'b0;
                        mem_resp <= 1'b1;
                        if (mem_write) begin
                            mem[mem_address[15:1]] = mem_wdata;
                            log_addr.push_back(mem_address);
                            log_data.push_back(mem_wdata);
                        end else begin
                            mem_rdata <= mem[mem_address[15:1]];
                        end
                    end
                end
            end
        end
    end

endmodule : sim_memory

// File: source/cpu.sv
module cpu import lc3b_types::*; (
    input logic clk,
    input logic rst,
    output logic mem_read,
    output logic mem_write,
    output lc3b_word mem_address,
    output lc3b_word mem_wdata,
    input logic mem_resp,
    input lc3b_word mem_rdata
);

    mem_port_if u_port_a ();
    mem_port_if u_port_b ();

    cpu_datapath u_datapath (
        .clk(clk),
        .rst(rst),
        .port_a(u_port_a.master),
        .port_b(u_port_b.master)
    );

    // instruction and data ports share the one external bus
    mem_arbiter u_arbiter (
        .clk(clk),
        .rst(rst),
        .port_a(u_port_a.slave),
        .port_b(u_port_b.slave),
        .mem_read(mem_read),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_resp(mem_resp),
        .mem_rdata(mem_rdata)
    );

endmodule : cpu

// File: source/mem_arbiter.sv
module mem_arbiter import lc3b_types::*; (
    input logic clk,
    input logic rst,
    mem_port_if.slave port_a,
    mem_port_if.slave port_b,
    output logic mem_read,
    output logic mem_write,
    output lc3b_word mem_address,
    output lc3b_word mem_wdata,
    input logic mem_resp,
    input lc3b_word mem_rdata
);

    typedef enum logic [1:0] {
        own_none,
        own_a,
        own_b
    } owner_t;

    owner_t owner;
    owner_t grant;

    // a new owner is only picked from idle, data port first
    always_comb begin
        grant = owner;
        if (owner == own_none) begin
            if (port_b.read || port_b.write) begin
                grant = own_b;
            end else if (port_a.read || port_a.write) begin
                grant = own_a;
            end
        end
    end

    always_comb begin
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_address = '0;
        mem_wdata = '0;
        case (grant)
            own_a: begin
                mem_read = port_a.read;
                mem_write = port_a.write;
                mem_address = port_a.address;
                mem_wdata = port_a.wdata;
            end
            own_b: begin
                mem_read = port_b.read;
                mem_write = port_b.write;
                mem_address = port_b.address;
                mem_wdata = port_b.wdata;
            end
            default: begin
            end
        endcase
    end

    assign port_a.resp = mem_resp && grant == own_a;
    assign port_b.resp = mem_resp && grant == own_b;
    assign port_a.rdata = mem_rdata;
    assign port_b.rdata = mem_rdata;

    always_ff @(posedge clk) begin
        if (rst || mem_resp) begin
            owner <= own_none;
        end else begin
            owner <= grant;
        end
    end

    // the owner's access stays on the bus unchanged until its resp
    owner_stable: assert property (@(posedge clk) disable iff (rst)
        ((mem_read || mem_write) && !mem_resp) |=>
            $stable({mem_read, mem_write, mem_address, mem_wdata}));

    // every resp reaches exactly one port
    single_resp: assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> $onehot({port_a.resp, port_b.resp}));

endmodule : mem_arbiter

// File: source/cpu_datapath.sv
module cpu_datapath import lc3b_types::*; (
    input logic clk,
    input logic rst,
    mem_port_if.master port_a,
    mem_port_if.master port_b
);

    localparam if_id_t if_id_bubble = '0;
    localparam id_ex_t id_ex_bubble = '0;
    localparam ex_mem_t ex_mem_bubble = '0;
    localparam mem_wb_t mem_wb_bubble = '0;

    if_id_t if_out, if_id_q;
    id_ex_t id_out, id_ex_q;
    ex_mem_t ex_out, ex_mem_q;
    mem_wb_t mem_out, mem_wb_q;

    logic fetch_wait, mem_wait, stall;
    logic br_taken, br_flush, load_use;
    logic [1:0] fwd_a, fwd_b;

    // a load in EX/MEM has no value yet, so only MEM/WB can serve then
    function automatic logic [1:0] fwd_sel(lc3b_reg src, ex_mem_t em, mem_wb_t mw);
        if (em.ctrl.load_regfile && !em.ctrl.mem_read && em.dest == src)
            return 2'b10;
        if (mw.ctrl.load_regfile && mw.dest == src)
            return 2'b01;
        return 2'b00;
    endfunction

    assign fwd_a = fwd_sel(id_ex_q.sr1, ex_mem_q, mem_wb_q);
    assign fwd_b = fwd_sel(id_ex_q.sr2, ex_mem_q, mem_wb_q);

    assign stall = fetch_wait || mem_wait;
    assign br_flush = br_taken && !stall;

    // a taken branch discards the consumer anyway
    assign load_use = id_ex_q.ctrl.mem_read && !br_taken &&
        (id_out.sr1 == id_ex_q.dest || id_out.sr2 == id_ex_q.dest);

    if_stage u_if (
        .clk(clk), .rst(rst), .stall(stall), .hold(load_use),
        .br_taken(br_taken), .br_target(ex_mem_q.target),
        .port_a(port_a), .fetch_wait(fetch_wait), .out(if_out)
    );

    stage_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .rst(rst), .load(!stall && !load_use), .flush(br_flush),
        .bubble(if_id_bubble), .d(if_out), .q(if_id_q)
    );

    id_stage u_id (
        .clk(clk), .rst(rst), .in(if_id_q), .wb(mem_wb_q), .out(id_out)
    );

    stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .rst(rst), .load(!stall), .flush(br_flush || (load_use && !stall)),
        .bubble(id_ex_bubble), .d(id_out), .q(id_ex_q)
    );

    ex_stage u_ex (
        .in(id_ex_q), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_fwd(ex_mem_q.alu), .wb_fwd(mem_wb_q.data), .out(ex_out)
    );

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .rst(rst), .load(!stall), .flush(br_flush),
        .bubble(ex_mem_bubble), .d(ex_out), .q(ex_mem_q)
    );

    mem_stage u_mem (
        .clk(clk), .rst(rst), .stall(stall), .in(ex_mem_q), .port_b(port_b),
        .mem_wait(mem_wait), .br_taken(br_taken), .out(mem_out)
    );

    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .rst(rst), .load(!stall), .flush(1'b0),
        .bubble(mem_wb_bubble), .d(mem_out), .q(mem_wb_q)
    );

endmodule : cpu_datapath

// File: source/mem_stage.sv
module mem_stage import lc3b_types::*; (
    input logic clk,
    input logic rst,
    input logic stall,
    input ex_mem_t in,
    mem_port_if.master port_b,
    output logic mem_wait,
    output logic br_taken,
    output mem_wb_t out
);

    logic access;
    logic done;
    lc3b_word rdata_buf;
    lc3b_word load_data;
    lc3b_word wb_data;
    logic [2:0] nzp;
    logic [2:0] cc;

    assign access = in.ctrl.mem_read || in.ctrl.mem_write;

    // once answered, the access is not issued again while IF still stalls
    assign port_b.read = in.ctrl.mem_read && !done;
    assign port_b.write = in.ctrl.mem_write && !done;
    assign port_b.address = in.alu;
    assign port_b.wdata = in.store_data;

    assign mem_wait = access && !done && !port_b.resp;

    always_ff @(posedge clk) begin
        if (rst || !stall) begin
            done <= 1'b0;
        end else if (port_b.resp) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (port_b.resp) begin
            rdata_buf <= port_b.rdata;
        end
    end

    assign load_data = done ? rdata_buf : port_b.rdata;
    assign wb_data = in.ctrl.mem_read ? load_data : in.alu;

    assign nzp = {wb_data[15], wb_data == '0, !wb_data[15] && wb_data != '0};

    always_ff @(posedge clk) begin
        if (rst) begin
            cc <= 3'b010;
        end else if (!stall && in.ctrl.load_cc) begin
            cc <= nzp;
        end
    end

    // the nzp mask of a BR sits in its dest field
    assign br_taken = in.ctrl.is_branch && |(in.dest & cc);

    assign out.ctrl = in.ctrl;
    assign out.dest = in.dest;
    assign out.data = wb_data;

    rw_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(port_b.read && port_b.write));

endmodule : mem_stage

// File: source/ex_stage.sv
module ex_stage import lc3b_types::*; (
    input id_ex_t in,
    input logic [1:0] fwd_a,
    input logic [1:0] fwd_b,
    input lc3b_word mem_fwd,
    input lc3b_word wb_fwd,
    output ex_mem_t out
);

    lc3b_word src_a;
    lc3b_word src_b;
    lc3b_word imm;
    lc3b_word alu_b;
    lc3b_word offset9;

    // 2'b10 takes EX/MEM, 2'b01 takes MEM/WB, anything else the register value
    function automatic lc3b_word fwd_mux(logic [1:0] sel, lc3b_word reg_val,
                                         lc3b_word mem_val, lc3b_word wb_val);
        case (sel)
            2'b10: return mem_val;
            2'b01: return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a = fwd_mux(fwd_a, in.sr1_data, mem_fwd, wb_fwd);
    assign src_b = fwd_mux(fwd_b, in.sr2_data, mem_fwd, wb_fwd);

    // memory offsets are word offsets, so offset6 is scaled by two
    assign imm = (in.ctrl.mem_read || in.ctrl.mem_write)
        ? {{9{in.instruction[5]}}, in.instruction[5:0], 1'b0}
        : {{11{in.instruction[4]}}, in.instruction[4:0]};
    assign alu_b = in.ctrl.sel_imm ? imm : src_b;

    always_comb begin
        case (in.ctrl.aluop)
            alu_add: out.alu = src_a + alu_b;
            alu_and: out.alu = src_a & alu_b;
            alu_not: out.alu = ~src_a;
            default: out.alu = alu_b;
        endcase
    end

    assign offset9 = {{6{in.instruction[8]}}, in.instruction[8:0], 1'b0};

    assign out.ctrl = in.ctrl;
    assign out.dest = in.dest;
    assign out.target = in.pc + 16'd2 + offset9;
    assign out.store_data = src_b;

endmodule : ex_stage

// File: source/id_stage.sv
`include "lc3b_consts.svh"

module id_stage import lc3b_types::*; (
    input logic clk,
    input logic rst,
    input if_id_t in,
    input mem_wb_t wb,
    output id_ex_t out
);

    lc3b_word regs [`LC3B_NUM_REGS];
    lc3b_control_word ctrl;
    lc3b_reg sr1;
    lc3b_reg sr2;

    always_comb begin
        ctrl = '0;
        case (in.instruction[15:12])
            `OP_ADD, `OP_AND: begin
                ctrl.opcode = (in.instruction[15:12] == `OP_ADD) ? op_add : op_and;
                ctrl.aluop = (in.instruction[15:12] == `OP_ADD) ? alu_add : alu_and;
                ctrl.sel_imm = in.instruction[5];
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            `OP_NOT: begin
                ctrl.opcode = op_not;
                ctrl.aluop = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end
            `OP_LDR: begin
                ctrl.opcode = op_ldr;
                ctrl.aluop = alu_add;
                ctrl.sel_imm = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                ctrl.mem_read = 1'b1;
            end
            `OP_STR: begin
                ctrl.opcode = op_str;
                ctrl.aluop = alu_add;
                ctrl.sel_imm = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            `OP_BR: begin
                ctrl.opcode = op_br;
                ctrl.aluop = alu_pass;
                ctrl.is_branch = 1'b1;
            end
            default: begin
                // anything outside the subset runs as a bubble
                ctrl = '0;
            end
        endcase
    end

    // STR reads its store data through the second source
    assign sr1 = in.instruction[8:6];
    assign sr2 = ctrl.mem_write ? in.instruction[11:9] : in.instruction[2:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.ctrl.load_regfile) begin
            regs[wb.dest] <= wb.data;
        end
    end

    assign out.ctrl = ctrl;
    assign out.pc = in.pc;
    assign out.instruction = in.instruction;
    assign out.sr1 = sr1;
    assign out.sr2 = sr2;
    assign out.dest = in.instruction[11:9];
    assign out.sr1_data = (wb.ctrl.load_regfile && wb.dest == sr1) ? wb.data : regs[sr1];
    assign out.sr2_data = (wb.ctrl.load_regfile && wb.dest == sr2) ? wb.data : regs[sr2];

endmodule : id_stage

// File: source/if_stage.sv
`include "lc3b_consts.svh"

module if_stage import lc3b_types::*; (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic hold,
    input logic br_taken,
    input lc3b_word br_target,
    mem_port_if.master port_a,
    output logic fetch_wait,
    output if_id_t out
);

    lc3b_word pc;
    lc3b_word inst_buf;
    logic valid;
    logic running;

    // fetch port never writes
    assign port_a.read = running && !valid;
    assign port_a.write = 1'b0;
    assign port_a.address = pc;
    assign port_a.wdata = '0;

    assign fetch_wait = !valid && !port_a.resp;

    assign out.pc = pc;
    assign out.instruction = valid ? inst_buf : port_a.rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `LC3B_RESET_PC;
            valid <= 1'b0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (br_taken && !stall) begin
                pc <= br_target;
                valid <= 1'b0;
            end else if (!stall && !hold) begin
                pc <= pc + 16'd2;
                valid <= 1'b0;
            end else if (port_a.resp) begin
                // keep the fetched word while the pipeline waits on port B
                valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (port_a.resp) begin
            inst_buf <= port_a.rdata;
        end
    end

endmodule : if_stage

// File: source/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic
) (
    input logic clk,
    input logic rst,
    input logic load,
    input logic flush,
    input payload_t bubble,
    input payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= bubble;
        end else if (load) begin
            q <= d;
        end
    end

    // a flush only lands on an edge where the whole pipeline moves
    flush_not_stalled: assert property (@(posedge clk) disable iff (rst)
        flush |-> load);

endmodule : stage_reg

// File: source/mem_port_if.sv
interface mem_port_if import lc3b_types::*; ();

    logic read;
    logic write;
    lc3b_word address;
    lc3b_word wdata;
    logic resp;
    lc3b_word rdata;

    modport master (
        output read,
        output write,
        output address,
        output wdata,
        input resp,
        input rdata
    );

    modport slave (
        input read,
        input write,
        input address,
        input wdata,
        output resp,
        output rdata
    );

endinterface : mem_port_if

// File: source/lc3b_types.sv
`include "lc3b_consts.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;

    typedef enum logic [3:0] {
        op_br = `OP_BR,
        op_add = `OP_ADD,
        op_and = `OP_AND,
        op_ldr = `OP_LDR,
        op_str = `OP_STR,
        op_not = `OP_NOT
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } alu_op_t;

    typedef struct packed {
        lc3b_opcode opcode;
        alu_op_t aluop;
        logic sel_imm;
        logic load_regfile;
        logic load_cc;
        logic mem_read;
        logic mem_write;
        logic is_branch;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_word pc;
        lc3b_word instruction;
    } if_id_t;

    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_word pc;
        lc3b_word instruction;
        lc3b_reg sr1;
        lc3b_reg sr2;
        lc3b_reg dest;
        lc3b_word sr1_data;
        lc3b_word sr2_data;
    } id_ex_t;

    // for BR the dest field carries the nzp mask
    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_reg dest;
        lc3b_word alu;
        lc3b_word target;
        lc3b_word store_data;
    } ex_mem_t;

    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_reg dest;
        lc3b_word data;
    } mem_wb_t;

endpackage : lc3b_types

// File: source/lc3b_consts.svh
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

// datapath width and register file size
`define LC3B_WORD_W 16
`define LC3B_NUM_REGS 8

// first fetch address after reset
`define LC3B_RESET_PC 16'h0000

// instruction bits [15:12] of the supported subset
`define OP_BR 4'b0000
`define OP_ADD 4'b0001
`define OP_AND 4'b0101
`define OP_LDR 4'b0110
`define OP_STR 4'b0111
`define OP_NOT 4'b1001

`endif
